// File: Makefile
TOP = tb_aes_round
LOG = sim.log

.PHONY: run lint clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	grep -q "=== PASS ===" $(LOG)

obj_dir/V$(TOP): flist.f *.sv
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: aes_add_round_key.sv
`timescale 1ns/1ns

module aes_add_round_key (
    input  logic            clk,
    input  logic            reset,
    input  logic            s2_valid,
    input  aes_pkg::state_t s2_state,
    input  logic            k2_valid,
    input  aes_pkg::state_t k2_key,
    input  logic            out_ready,
    output logic            hold,
    output logic            in_ready,
    output logic            out_valid,
    output aes_pkg::state_t out_state,
    output aes_pkg::state_t out_key
);

    // full output register that nobody takes, so freeze everything
    assign hold = out_valid && !out_ready;

    // source side sees the same stall
    assign in_ready = !hold;

    // both paths advance on hold, so their valid bits line up
    always_ff @(posedge clk)
    begin
        if (!reset)
            out_valid <= 1'b0;
        else if (!hold)
            out_valid <= s2_valid && k2_valid;
    end

    // AddRoundKey, the new key goes out beside the state
    always_ff @(posedge clk)
    begin
        if (!hold)
        begin
            out_state <= s2_state ^ k2_key;
            out_key   <= k2_key;
        end
    end

endmodule

// File: aes_key_step.sv
`timescale 1ns/1ns

module aes_key_step (
    input  logic            clk,
    input  logic            reset,
    input  logic            hold,
    input  logic            in_valid,
    input  aes_pkg::state_t in_key,
    input  aes_pkg::round_t in_round,
    output logic            k2_valid,
    output aes_pkg::state_t k2_key
);

    // RotWord of the last key word, a byte left
    logic [31:0] rot_w3;
    // SubWord result, driven slice by slice
    wire  [31:0] sub_word;

    // stage 1 registers
    logic            k1_valid;
    aes_pkg::state_t k1_key;
    logic [31:0]     k1_temp;

    // stage 2 input, the four new words
    aes_pkg::state_t nxt_key;

    // round constant, only the top byte is non-zero
    function automatic logic [7:0] rcon(input aes_pkg::round_t r);
        case (r)
            4'd1:    return 8'h01;
            4'd2:    return 8'h02;
            4'd3:    return 8'h04;
            4'd4:    return 8'h08;
            4'd5:    return 8'h10;
            4'd6:    return 8'h20;
            4'd7:    return 8'h40;
            4'd8:    return 8'h80;
            4'd9:    return 8'h1b;
            4'd10:   return 8'h36;
            default: return 8'h00;
        endcase
    endfunction

    assign rot_w3 = {in_key.cols[3][23:0], in_key.cols[3][31:24]};

    // four S-boxes of its own, not shared with the state path
    genvar j;
    generate
        for (j = 0; j < 4; j++)
        begin : g_sbox
            aes_sbox u_sbox (
                .in_byte  (rot_w3[8*j +: 8]),
                .out_byte (sub_word[8*j +: 8])
            );
        end
    endgenerate

    // XOR chain, each word folds in the one before
    always_comb
    begin
        logic [31:0] w;
        w = k1_temp;
        for (int i = 0; i < aes_pkg::NUM_COLS; i++)
        begin
            w = w ^ k1_key.cols[i];
            nxt_key.cols[i] = w;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            k1_valid <= 1'b0;
            k2_valid <= 1'b0;
        end
        else if (!hold)
        begin
            k1_valid <= in_valid;
            k2_valid <= k1_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!hold)
        begin
            // old key plus the temp word
            k1_key  <= in_key;
            k1_temp <= sub_word ^ {rcon(in_round), 24'h000000};
            k2_key  <= nxt_key;
        end
    end

endmodule

// File: aes_mix_columns.sv
`timescale 1ns/1ns

module aes_mix_columns (
    input  logic            clk,
    input  logic            reset,
    input  logic            hold,
    input  logic            s1_valid,
    input  aes_pkg::state_t s1_state,
    input  aes_pkg::round_t s1_round,
    output logic            s2_valid,
    output aes_pkg::state_t s2_state
);

    // mixed state, or the bypass in the last round
    aes_pkg::state_t mixed;

    // times 2, top bit out means reduce by 0x1b
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // times 3 is times 2 plus the byte itself
    function automatic logic [7:0] mul3(input logic [7:0] a);
        return xtime(a) ^ a;
    endfunction

    // one column times the circulant 2 3 1 1
    function automatic logic [31:0] mix_col(input logic [31:0] col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        // row 0 sits in the top byte
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {
            xtime(a0) ^ mul3(a1) ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ mul3(a2) ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ mul3(a3),
            mul3(a0) ^ a1 ^ a2 ^ xtime(a3)
        };
    endfunction

    always_comb
    begin
        // round 10 has no MixColumns
        if (s1_round == aes_pkg::round_t'(aes_pkg::NUM_ROUNDS))
            mixed = s1_state;
        else
        begin
            for (int c = 0; c < aes_pkg::NUM_COLS; c++)
                mixed.cols[c] = mix_col(s1_state.cols[c]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
            s2_valid <= 1'b0;
        else if (!hold)
            s2_valid <= s1_valid;
    end

    // bubbles load too, the valid bit marks them
    always_ff @(posedge clk)
    begin
        if (!hold)
            s2_state <= mixed;
    end

endmodule

// File: aes_pkg.sv
package aes_pkg;

    // AES-128 only, state and key are the same width
    localparam int BLOCK_BITS = 128;

    // index of the last round, the one without MixColumns
    localparam int NUM_ROUNDS = 10;

    // state geometry, 4 rows by 4 columns of bytes
    localparam int NUM_ROWS  = 4;
    localparam int NUM_COLS  = BLOCK_BITS / 32;
    localparam int NUM_BYTES = BLOCK_BITS / 8;

    // round number, 1..10 in use
    typedef logic [3:0] round_t;

    // one 128-bit state word seen two ways
    // bytes view: byte k is row k mod 4, column k div 4
    // cols view: one 32-bit word per column, row 0 in the top byte
    // element 0 is the most significant in both (FIPS-197 order)
    typedef union packed {
        logic [0:NUM_BYTES-1][7:0] bytes;
        logic [0:NUM_COLS-1][31:0] cols;
    } state_t;

    // position of (row, col) inside the bytes view
    function automatic int byte_idx(input int row, input int col);
        return col * NUM_ROWS + row;
    endfunction

endpackage

// File: aes_round.sv
`timescale 1ns/1ns

module aes_round (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    output logic            in_ready,
    input  aes_pkg::state_t in_state,
    input  aes_pkg::state_t in_key,
    input  aes_pkg::round_t in_round,
    output logic            out_valid,
    input  logic            out_ready,
    output aes_pkg::state_t out_state,
    output aes_pkg::state_t out_key
);

    // global stall from the combiner
    logic hold;

    // state path, stage 1 to stage 2
    logic            s1_valid;
    aes_pkg::state_t s1_state;
    aes_pkg::round_t s1_round;

    // state path into the combiner
    logic            s2_valid;
    aes_pkg::state_t s2_state;

    // key path into the combiner
    logic            k2_valid;
    aes_pkg::state_t k2_key;

    aes_sub_shift u_sub_shift (
        .clk      (clk),
        .reset    (reset),
        .hold     (hold),
        .in_valid (in_valid),
        .in_state (in_state),
        .in_round (in_round),
        .s1_valid (s1_valid),
        .s1_state (s1_state),
        .s1_round (s1_round)
    );

    aes_mix_columns u_mix_columns (
        .clk      (clk),
        .reset    (reset),
        .hold     (hold),
        .s1_valid (s1_valid),
        .s1_state (s1_state),
        .s1_round (s1_round),
        .s2_valid (s2_valid),
        .s2_state (s2_state)
    );

    // key expansion runs beside the state path, same depth
    aes_key_step u_key_step (
        .clk      (clk),
        .reset    (reset),
        .hold     (hold),
        .in_valid (in_valid),
        .in_key   (in_key),
        .in_round (in_round),
        .k2_valid (k2_valid),
        .k2_key   (k2_key)
    );

    aes_add_round_key u_add_round_key (
        .clk       (clk),
        .reset     (reset),
        .s2_valid  (s2_valid),
        .s2_state  (s2_state),
        .k2_valid  (k2_valid),
        .k2_key    (k2_key),
        .out_ready (out_ready),
        .hold      (hold),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_state (out_state),
        .out_key   (out_key)
    );

endmodule

// File: aes_round_asserts.sv
`timescale 1ns/1ns

module aes_round_asserts (
    input logic         clk,
    input logic         reset,
    input logic         s2_valid,
    input logic         k2_valid,
    input logic         out_valid,
    input logic         out_ready,
    input logic [127:0] out_state,
    input logic [127:0] out_key
);

    int failures = 0;

    // one stall for both paths, so valid bits agree
    a_lockstep : assert property (@(posedge clk) disable iff (!reset) s2_valid == k2_valid)
    else
    begin
        failures++;
        $error("state and key path valid bits differ");
    end

    // stalled output holds its data
    a_stable : assert property (@(posedge clk) disable iff (!reset)
        out_valid && !out_ready |=> $stable(out_state) && $stable(out_key))
    else
    begin
        failures++;
        $error("output changed while stalled");
    end

    a_reset : assert property (@(posedge clk) !reset |=> !out_valid)
    else
    begin
        failures++;
        $error("out_valid high after reset");
    end

endmodule

bind aes_add_round_key aes_round_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .s2_valid  (s2_valid),
    .k2_valid  (k2_valid),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_state (out_state),
    .out_key   (out_key)
);

// File: aes_round_checker.sv
`timescale 1ns/1ns

module aes_round_checker (
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  logic         in_ready,
    input  logic [127:0] in_state,
    input  logic [127:0] in_key,
    input  logic [3:0]   in_round,
    input  logic         out_valid,
    input  logic         out_ready,
    input  logic [127:0] out_state,
    input  logic [127:0] out_key,
    input  logic         latency_check,
    input  logic         const_valid,
    input  logic [127:0] const_state,
    input  logic [127:0] const_key,
    input  logic         test_done,
    input  int           test_num,
    output int           in_count,
    output int           out_count,
    output int           tests_passed,
    output int           tests_failed
);

    logic [7:0]   sbox [256];
    // accepted inputs, state in the top half
    logic [255:0] q_data [$];
    logic [3:0]   q_round [$];
    int           q_cycle [$];
    int           cycle;
    int           errors;
    logic         reset_q;

    // carry-less product, then reduce by 0x11b
    function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
        logic [15:0] p;
        p = 16'h0000;
        for (int i = 0; i < 8; i++)
            if (b[i])
                p = p ^ (16'(a) << i);
        for (int i = 15; i >= 8; i--)
            if (p[i])
                p = p ^ (16'h011b << (i - 8));
        return p[7:0];
    endfunction

    // returns {new key, new state}
    function automatic logic [255:0] model(input logic [0:15][7:0] sb,
                                           input logic [0:3][31:0] kw, input logic [3:0] rnd);
        logic [7:0]       b [16];
        logic [0:15][7:0] ns;
        logic [0:3][31:0] nk;
        logic [31:0]      t;
        logic [7:0]       rc;
        // byte 4c+r comes from row r, column c+r
        for (int k = 0; k < 16; k++)
            b[k] = sbox[sb[4 * ((k / 4 + k % 4) % 4) + k % 4]];
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                ns[4*c+r] = (rnd == 4'd10) ? b[4*c+r] :
                    gmul(b[4*c+r], 8'h02) ^ gmul(b[4*c+(r+1)%4], 8'h03)
                    ^ b[4*c+(r+2)%4] ^ b[4*c+(r+3)%4];
        // rcon by repeated doubling
        rc = 8'h01;
        for (int i = 1; i < int'(rnd); i++)
            rc = gmul(rc, 8'h02);
        t = kw[3];
        t = {sbox[t[23:16]], sbox[t[15:8]], sbox[t[7:0]], sbox[t[31:24]]} ^ {rc, 24'h000000};
        for (int i = 0; i < 4; i++)
        begin
            t = t ^ kw[i];
            nk[i] = t;
        end
        return {nk, ns ^ nk};
    endfunction

    task automatic report(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // S-box by brute-force inverse and the bitwise affine rule
    initial
    begin
        logic [7:0] inv;
        logic [7:0] s;
        for (int a = 0; a < 256; a++)
        begin
            inv = 8'h00;
            for (int v = 1; v < 256; v++)
                if (gmul(8'(a), 8'(v)) == 8'h01)
                    inv = 8'(v);
            for (int i = 0; i < 8; i++)
                s[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8];
            sbox[a] = s ^ 8'h63;
        end
    end

    always @(posedge clk)
    begin
        logic [255:0] expv;
        cycle++;
        if (!reset)
        begin
            q_data.delete();
            q_round.delete();
            q_cycle.delete();
            {cycle, errors, in_count, out_count, tests_passed, tests_failed} = '0;
        end
        else
        begin
            // first edge out of reset sees the reset values
            if (!reset_q && (out_valid || !in_ready))
                report("out_valid or in_ready wrong after reset");
            if (in_valid && in_ready)
            begin
                q_data.push_back({in_state, in_key});
                q_round.push_back(in_round);
                q_cycle.push_back(cycle);
                in_count++;
            end
            if (out_valid && out_ready)
            begin
                out_count++;
                if (q_data.size() == 0)
                    report("output transfer with no input pending");
                else
                begin
                    expv = model(q_data[0][255:128], q_data[0][127:0], q_round[0]);
                    if (out_state !== expv[127:0])
                        report($sformatf("state %h, expected %h", out_state, expv[127:0]));
                    if (out_key !== expv[255:128])
                        report($sformatf("key %h, expected %h", out_key, expv[255:128]));
                    if (latency_check && cycle - q_cycle[0] != 3)
                        report($sformatf("latency %0d cycles, expected 3", cycle - q_cycle[0]));
                    if (const_valid && (out_state !== const_state || out_key !== const_key))
                        report("output differs from the FIPS-197 vector");
                    void'(q_data.pop_front());
                    void'(q_round.pop_front());
                    void'(q_cycle.pop_front());
                end
            end
            if (test_done)
            begin
                if (q_data.size() != 0)
                    report($sformatf("%0d inputs never came out", q_data.size()));
                $display("test %0d finished, %0d errors", test_num, errors);
                if (errors == 0)
                    tests_passed++;
                else
                    tests_failed++;
                errors = 0;
            end
        end
        reset_q = reset;
    end

endmodule

// File: aes_sbox.sv
`timescale 1ns/1ns

module aes_sbox (
    input  logic [7:0] in_byte,
    output logic [7:0] out_byte
);

    // multiply by x, reduce by 0x11b
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // shift-and-add product in GF(2^8)
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ sh;
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // inverse as a^254 since a^255 = 1
    // zero falls out as zero with no special case
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] a2;
        logic [7:0] a3;
        logic [7:0] a12;
        logic [7:0] a15;
        logic [7:0] a240;
        a2   = gf_mul(a, a);
        a3   = gf_mul(a2, a);
        // a^12 from two squarings of a^3
        a12  = gf_mul(a3, a3);
        a12  = gf_mul(a12, a12);
        a15  = gf_mul(a12, a3);
        // four squarings take a^15 to a^240
        a240 = a15;
        for (int i = 0; i < 4; i++)
            a240 = gf_mul(a240, a240);
        // 240 + 12 + 2 = 254
        return gf_mul(gf_mul(a240, a12), a2);
    endfunction

    // FIPS affine map, b ^ rotations 1..4 ^ 0x63
    function automatic logic [7:0] affine(input logic [7:0] b);
        return b
            ^ {b[6:0], b[7]}
            ^ {b[5:0], b[7:6]}
            ^ {b[4:0], b[7:5]}
            ^ {b[3:0], b[7:4]}
            ^ 8'h63;
    endfunction

    // pure logic, no table
    assign out_byte = affine(gf_inv(in_byte));

endmodule

// File: aes_sub_shift.sv
`timescale 1ns/1ns

module aes_sub_shift (
    input  logic            clk,
    input  logic            reset,
    input  logic            hold,
    input  logic            in_valid,
    input  aes_pkg::state_t in_state,
    input  aes_pkg::round_t in_round,
    output logic            s1_valid,
    output aes_pkg::state_t s1_state,
    output aes_pkg::round_t s1_round
);

    // substituted bytes, still in input order
    logic [7:0] sub_byte [aes_pkg::NUM_BYTES];

    // after ShiftRows
    aes_pkg::state_t shifted;

    // one S-box per state byte
    genvar k;
    generate
        for (k = 0; k < aes_pkg::NUM_BYTES; k++)
        begin : g_sbox
            aes_sbox u_sbox (
                .in_byte  (in_state.bytes[k]),
                .out_byte (sub_byte[k])
            );
        end
    endgenerate

    // row r turns left by r places
    // out(r, c) takes in(r, c + r mod 4)
    always_comb
    begin
        for (int c = 0; c < aes_pkg::NUM_COLS; c++)
        begin
            for (int r = 0; r < aes_pkg::NUM_ROWS; r++)
            begin
                shifted.bytes[aes_pkg::byte_idx(r, c)] =
                    sub_byte[aes_pkg::byte_idx(r, (c + r) % aes_pkg::NUM_COLS)];
            end
        end
    end

    // stage valid, frozen with the rest of the pipe
    always_ff @(posedge clk)
    begin
        if (!reset)
            s1_valid <= 1'b0;
        else if (!hold)
            s1_valid <= in_valid;
    end

    // payload travels with its round number
    always_ff @(posedge clk)
    begin
        if (!hold)
        begin
            s1_state <= shifted;
            s1_round <= in_round;
        end
    end

endmodule

// File: flist.f
aes_pkg.sv
aes_sbox.sv
aes_sub_shift.sv
aes_mix_columns.sv
aes_key_step.sv
aes_add_round_key.sv
aes_round.sv
aes_round_asserts.sv
aes_round_checker.sv
tb_aes_round.sv

// File: tb_aes_round.sv
`timescale 1ns/1ns

module tb_aes_round;

    // cycles any single wait may take
    localparam int LIMIT = 200;

    logic         clk;
    logic         reset;
    logic         in_valid;
    logic         out_ready;
    logic [127:0] in_state;
    logic [127:0] in_key;
    logic [3:0]   in_round;
    wire          in_ready;
    wire          out_valid;
    wire  [127:0] out_state;
    wire  [127:0] out_key;
    logic         latency_check;
    logic         const_valid;
    logic [127:0] const_state;
    logic [127:0] const_key;
    logic         test_done;
    int           test_num;
    int           in_count;
    int           out_count;
    int           tests_passed;
    int           tests_failed;
    logic         random_ready;
    logic         timed_out;
    integer       seed;
    integer       draw;

    aes_round u_aes_round (.*);

    aes_round_checker u_checker (.*);

    initial
        clk = 1'b0;

    always #20 clk = ~clk;

    function automatic logic [127:0] random_block();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // one falling edge, out_ready redrawn under back-pressure
    task automatic next_cycle();
        @(negedge clk);
        if (random_ready)
        begin
            draw = $random(seed);
            out_ready = draw[0];
        end
    endtask

    // later waits fall through once this is set
    task automatic flag_timeout(input string what);
        $display("timeout, no progress while waiting for %s", what);
        timed_out = 1'b1;
    endtask

    // present one input until the checker sees it taken
    task automatic send(input logic [127:0] st, input logic [127:0] key, input logic [3:0] r);
        int start;
        int waited;
        start    = in_count;
        waited   = 0;
        in_valid = 1'b1;
        in_state = st;
        in_key   = key;
        in_round = r;
        while (in_count == start && !timed_out)
        begin
            if (waited == LIMIT)
                flag_timeout("in_ready");
            else
            begin
                next_cycle();
                waited++;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (out_count != in_count && !timed_out)
        begin
            if (waited == LIMIT)
                flag_timeout("the pipeline to drain");
            else
            begin
                next_cycle();
                waited++;
            end
        end
    endtask

    task automatic end_test(input int n);
        test_num  = n;
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    initial
    begin
        seed          = 32'hf8ec;
        reset         = 1'b0;
        in_valid      = 1'b0;
        in_state      = '0;
        in_key        = '0;
        in_round      = 4'd1;
        out_ready     = 1'b1;
        latency_check = 1'b0;
        const_valid   = 1'b0;
        const_state   = '0;
        const_key     = '0;
        test_done     = 1'b0;
        test_num      = 0;
        random_ready  = 1'b0;
        timed_out     = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        // idle outputs are checked on the first edge out of reset
        end_test(1);

        latency_check = 1'b1;
        repeat (200) send(random_block(), random_block(), 4'(1 + $unsigned($random(seed)) % 9));
        drain();
        end_test(2);

        // final round, no MixColumns
        repeat (20) send(random_block(), random_block(), 4'd10);
        drain();
        end_test(3);

        latency_check = 1'b0;
        random_ready  = 1'b1;
        repeat (200) send(random_block(), random_block(), 4'(1 + $unsigned($random(seed)) % 10));
        drain();
        random_ready = 1'b0;
        out_ready    = 1'b1;
        end_test(4);

        // FIPS-197 appendix B, round 1
        latency_check = 1'b1;
        const_valid   = 1'b1;
        const_state   = 128'ha49c7ff2689f352b6b5bea43026a5049;
        const_key     = 128'ha0fafe1788542cb123a339392a6c7605;
        send(128'h193de3bea0f4e22b9ac68d2ae9f84808, 128'h2b7e151628aed2a6abf7158809cf4f3c, 4'd1);
        drain();
        const_valid = 1'b0;
        end_test(5);

        $display("tests passed %0d, failed %0d, assertion failures %0d",
            tests_passed, tests_failed, u_aes_round.u_add_round_key.u_asserts.failures);
        if (tests_failed == 0 && u_aes_round.u_add_round_key.u_asserts.failures == 0
            && !timed_out)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
